/* design/hci_flow_pkg.sv */
// Shared types and field positions for the HCI command flow front end
// Only immediate-data writes to legacy I2C devices are decoded

package hci_flow_pkg;

  // Descriptor and table entry containers
  typedef logic [63:0] cmd_desc_t;
  typedef logic [31:0] resp_desc_t;
  typedef logic [31:0] dat_entry_t;
  typedef logic [4:0]  dat_index_t;
  typedef logic [7:0]  fmt_byte_t;
  // Byte position inside one transfer, 0 is the address byte
  typedef logic [2:0]  byte_cnt_t;

  // Command attribute codes as in the HCI command descriptor
  typedef enum logic [2:0] {
    RegularTransfer       = 3'b000,
    ImmediateDataTransfer = 3'b001,
    AddressAssignment     = 3'b010,
    ComboTransfer         = 3'b011,
    InternalControl       = 3'b111
  } cmd_attr_e;

  typedef enum logic [3:0] {
    RespSuccess      = 4'h0,
    RespNotSupported = 4'hA
  } resp_status_e;

  typedef enum logic [2:0] {
    Idle,
    FetchCmd,
    ReadDat,
    Decode,
    I2cWrite,
    WriteResp
  } flow_state_e;

  // Command descriptor fields
  localparam int unsigned CmdAttrLsb   = 0;
  localparam int unsigned CmdTidLsb    = 3;
  localparam int unsigned CmdDevIdxLsb = 16;
  localparam int unsigned CmdDttLsb    = 23;
  localparam int unsigned CmdRnwBit    = 29;
  localparam int unsigned CmdTocBit    = 31;
  // Data byte 1 starts here, bytes 2..4 follow upward
  localparam int unsigned CmdDataLsb   = 32;
  localparam int unsigned TidW         = 4;
  localparam int unsigned DttW         = 3;

  // Response descriptor fields
  localparam int unsigned RespStatusLsb = 28;
  localparam int unsigned RespTidLsb    = 24;
  localparam int unsigned RespLenLsb    = 0;
  localparam int unsigned RespLenW      = 16;

  // DAT entry fields
  localparam int unsigned DatAddrLsb  = 16;
  localparam int unsigned StaticAddrW = 7;
  localparam int unsigned DatI2cBit   = 31;

endpackage

/* design/hci_queue.sv */
// Synchronous valid/ready FIFO, data appears on the read side one cycle after a write
// Simultaneous push and pop are allowed, wready_o drops only when full
`timescale 1ns/1ps

module hci_queue #(
  parameter int unsigned Depth = 4,
  parameter int unsigned Width = 64
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  fill_q;
  logic             push;
  logic             pop;

  // Pointer advance with wrap, depth need not be a power of two
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full and empty from the fill count
  assign wready_o = (fill_q != CntW'(Depth));
  assign rvalid_o = (fill_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      fill_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_next(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_next(rptr_q);
      end
      // Count only moves when exactly one side transfers
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

/* design/dat_table.sv */
// Device address table, up to 32 entries, registered read with one cycle latency
// Out-of-range writes are ignored and out-of-range reads return zero
`timescale 1ns/1ps

module dat_table #(
  parameter int unsigned DatDepth = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wen_i,
  input  hci_flow_pkg::dat_index_t waddr_i,
  input  hci_flow_pkg::dat_entry_t wdata_i,
  input  logic                    rd_req_i,
  input  hci_flow_pkg::dat_index_t rd_index_i,
  output hci_flow_pkg::dat_entry_t rd_data_o
);

  hci_flow_pkg::dat_entry_t entries_q [DatDepth];

  // Software write port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DatDepth; i++) begin
        entries_q[i] <= '0;
      end
    end else if (wen_i && (waddr_i < DatDepth)) begin
      entries_q[waddr_i] <= wdata_i;
    end
  end

  // Read data is held until the next request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else if (rd_req_i) begin
      rd_data_o <= (rd_index_i < DatDepth) ? entries_q[rd_index_i] : '0;
    end
  end

endmodule

/* design/flow_fsm.sv */
// Command flow FSM, one command at a time from pop to response push
// Pop to first format byte is three cycles, unsupported commands skip straight to the response
`timescale 1ns/1ps

module flow_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flow_en_i,
  // Command queue read side
  input  logic                     cmd_rvalid_i,
  output logic                     cmd_rready_o,
  input  hci_flow_pkg::cmd_desc_t  cmd_rdata_i,
  // DAT read port
  output logic                     dat_rd_req_o,
  output hci_flow_pkg::dat_index_t dat_rd_index_o,
  input  hci_flow_pkg::dat_entry_t dat_rd_data_i,
  // Held command context for the byte selector
  output hci_flow_pkg::cmd_desc_t  cmd_desc_o,
  output hci_flow_pkg::dat_entry_t dat_entry_o,
  // Byte counter control
  output logic                     cnt_clr_o,
  output logic                     cnt_inc_o,
  input  logic                     cnt_last_i,
  // Format byte handshake
  output logic                     fmt_valid_o,
  input  logic                     fmt_ready_i,
  // Response queue write side
  output logic                     resp_wvalid_o,
  input  logic                     resp_wready_i,
  output hci_flow_pkg::resp_desc_t resp_wdata_o,
  output logic                     flow_idle_o
);

  hci_flow_pkg::flow_state_e  state_q;
  hci_flow_pkg::flow_state_e  state_d;
  hci_flow_pkg::resp_status_e status_q;
  hci_flow_pkg::cmd_desc_t    cmd_desc_q;
  hci_flow_pkg::dat_entry_t   dat_entry_q;
  logic                       is_imm;
  logic                       is_write;
  logic                       supported;

  // Support check uses the DAT data as it arrives in Decode
  assign is_imm = (cmd_desc_q[hci_flow_pkg::CmdAttrLsb +: $bits(hci_flow_pkg::cmd_attr_e)]
                   == hci_flow_pkg::ImmediateDataTransfer);
  assign is_write  = !cmd_desc_q[hci_flow_pkg::CmdRnwBit];
  assign supported = is_imm && is_write && dat_rd_data_i[hci_flow_pkg::DatI2cBit];

  // State outputs
  assign flow_idle_o    = (state_q == hci_flow_pkg::Idle);
  assign cmd_rready_o   = (state_q == hci_flow_pkg::FetchCmd);
  assign dat_rd_req_o   = (state_q == hci_flow_pkg::ReadDat);
  assign dat_rd_index_o = cmd_desc_q[hci_flow_pkg::CmdDevIdxLsb +: $bits(hci_flow_pkg::dat_index_t)];
  assign cnt_clr_o      = (state_q == hci_flow_pkg::Decode);
  assign fmt_valid_o    = (state_q == hci_flow_pkg::I2cWrite);
  assign cnt_inc_o      = fmt_valid_o & fmt_ready_i;
  assign resp_wvalid_o  = (state_q == hci_flow_pkg::WriteResp);
  assign cmd_desc_o     = cmd_desc_q;
  assign dat_entry_o    = dat_entry_q;

  // Response descriptor, data length is zero for writes
  always_comb begin
    resp_wdata_o = '0;
    resp_wdata_o[hci_flow_pkg::RespStatusLsb +: 4] = status_q;
    resp_wdata_o[hci_flow_pkg::RespTidLsb +: hci_flow_pkg::TidW] =
        cmd_desc_q[hci_flow_pkg::CmdTidLsb +: hci_flow_pkg::TidW];
    resp_wdata_o[hci_flow_pkg::RespLenLsb +: hci_flow_pkg::RespLenW] = '0;
  end

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      hci_flow_pkg::Idle: begin
        if (flow_en_i && cmd_rvalid_i) begin
          state_d = hci_flow_pkg::FetchCmd;
        end
      end
      // Queue stays valid, only this FSM pops it
      hci_flow_pkg::FetchCmd: state_d = hci_flow_pkg::ReadDat;
      hci_flow_pkg::ReadDat:  state_d = hci_flow_pkg::Decode;
      hci_flow_pkg::Decode: begin
        state_d = supported ? hci_flow_pkg::I2cWrite : hci_flow_pkg::WriteResp;
      end
      hci_flow_pkg::I2cWrite: begin
        // Done once the last byte is taken
        if (fmt_ready_i && cnt_last_i) begin
          state_d = hci_flow_pkg::WriteResp;
        end
      end
      hci_flow_pkg::WriteResp: begin
        if (resp_wready_i) begin
          state_d = hci_flow_pkg::Idle;
        end
      end
      default: state_d = hci_flow_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= hci_flow_pkg::Idle;
      status_q <= hci_flow_pkg::RespSuccess;
    end else begin
      state_q <= state_d;
      if (state_q == hci_flow_pkg::Decode) begin
        status_q <= supported ? hci_flow_pkg::RespSuccess : hci_flow_pkg::RespNotSupported;
      end
    end
  end

  // Descriptor and DAT entry held for the whole command
  always_ff @(posedge clk_i) begin
    if (cmd_rready_o) begin
      cmd_desc_q <= cmd_rdata_i;
    end
    if (state_q == hci_flow_pkg::Decode) begin
      dat_entry_q <= dat_rd_data_i;
    end
  end

endmodule

/* design/transfer_counter.sv */
// Byte position counter, clear wins over increment
`timescale 1ns/1ps

module transfer_counter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clr_i,
  input  logic                    inc_i,
  input  hci_flow_pkg::byte_cnt_t target_i,
  output hci_flow_pkg::byte_cnt_t count_o,
  output logic                    last_o
);

  hci_flow_pkg::byte_cnt_t count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (inc_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;
  // Single compare shared by the FSM and the stop flag
  assign last_o  = (count_q == target_i);

endmodule

/* design/imm_byte_sel.sv */
// Format byte mux for immediate writes, address byte first, then payload
// A defining byte in dtt 5..7 is never sent to the I2C device
`timescale 1ns/1ps

module imm_byte_sel (
  input  hci_flow_pkg::cmd_desc_t  cmd_desc_i,
  input  hci_flow_pkg::dat_entry_t dat_entry_i,
  input  hci_flow_pkg::byte_cnt_t  count_i,
  input  logic                     last_i,
  output hci_flow_pkg::byte_cnt_t  payload_len_o,
  output hci_flow_pkg::fmt_byte_t  fmt_byte_o,
  output logic                     fmt_start_o,
  output logic                     fmt_stop_o
);

  logic [hci_flow_pkg::DttW-1:0] dtt;
  logic                          use_def_byte;
  hci_flow_pkg::byte_cnt_t       data_idx;

  assign dtt          = cmd_desc_i[hci_flow_pkg::CmdDttLsb +: hci_flow_pkg::DttW];
  assign use_def_byte = (dtt > 3'd4);
  // Payload length in bytes
  assign payload_len_o = use_def_byte ? (dtt - 3'd5) : dtt;
  // Skip data byte 1 when it holds the defining byte
  assign data_idx = count_i + {2'b00, use_def_byte};

  always_comb begin
    unique case (count_i)
      // Static address with write bit
      3'd0: fmt_byte_o = {dat_entry_i[hci_flow_pkg::DatAddrLsb +: hci_flow_pkg::StaticAddrW], 1'b0};
      default: begin
        unique case (data_idx)
          3'd1:    fmt_byte_o = cmd_desc_i[hci_flow_pkg::CmdDataLsb      +: 8];
          3'd2:    fmt_byte_o = cmd_desc_i[hci_flow_pkg::CmdDataLsb + 8  +: 8];
          3'd3:    fmt_byte_o = cmd_desc_i[hci_flow_pkg::CmdDataLsb + 16 +: 8];
          3'd4:    fmt_byte_o = cmd_desc_i[hci_flow_pkg::CmdDataLsb + 24 +: 8];
          default: fmt_byte_o = '0;
        endcase
      end
    endcase
  end

  // Start before the address byte, stop after the last byte if toc asks for it
  assign fmt_start_o = (count_i == '0);
  assign fmt_stop_o  = last_i & cmd_desc_i[hci_flow_pkg::CmdTocBit];

endmodule

/* design/hci_flow_top.sv */
// HCI command flow front end for legacy I2C immediate writes
// All external ports use valid/ready, the I2C bus engine sits outside
`timescale 1ns/1ps

module hci_flow_top #(
  parameter int unsigned CmdDepth  = 4,
  parameter int unsigned RespDepth = 4,
  parameter int unsigned DatDepth  = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Command queue push
  input  logic                     cmd_wvalid_i,
  output logic                     cmd_wready_o,
  input  hci_flow_pkg::cmd_desc_t  cmd_wdata_i,
  // DAT programming
  input  logic                     dat_wen_i,
  input  hci_flow_pkg::dat_index_t dat_waddr_i,
  input  hci_flow_pkg::dat_entry_t dat_wdata_i,
  input  logic                     flow_en_i,
  // Format bytes to the I2C bus engine
  output logic                     fmt_valid_o,
  input  logic                     fmt_ready_i,
  output hci_flow_pkg::fmt_byte_t  fmt_byte_o,
  output logic                     fmt_start_o,
  output logic                     fmt_stop_o,
  // Response queue pop
  output logic                     resp_rvalid_o,
  input  logic                     resp_rready_i,
  output hci_flow_pkg::resp_desc_t resp_rdata_o,
  output logic                     flow_idle_o
);

  logic                     cmd_rvalid;
  logic                     cmd_rready;
  hci_flow_pkg::cmd_desc_t  cmd_rdata;
  logic                     dat_rd_req;
  hci_flow_pkg::dat_index_t dat_rd_index;
  hci_flow_pkg::dat_entry_t dat_rd_data;
  hci_flow_pkg::cmd_desc_t  cmd_desc;
  hci_flow_pkg::dat_entry_t dat_entry;
  logic                     cnt_clr;
  logic                     cnt_inc;
  logic                     cnt_last;
  hci_flow_pkg::byte_cnt_t  cnt_value;
  hci_flow_pkg::byte_cnt_t  payload_len;
  logic                     resp_wvalid;
  logic                     resp_wready;
  hci_flow_pkg::resp_desc_t resp_wdata;

  // Command queue
  hci_queue #(
    .Depth(CmdDepth),
    .Width($bits(hci_flow_pkg::cmd_desc_t))
  ) cmd_queue_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(cmd_wvalid_i),
    .wready_o(cmd_wready_o),
    .wdata_i (cmd_wdata_i),
    .rvalid_o(cmd_rvalid),
    .rready_i(cmd_rready),
    .rdata_o (cmd_rdata)
  );

  dat_table #(
    .DatDepth(DatDepth)
  ) dat_table_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wen_i     (dat_wen_i),
    .waddr_i   (dat_waddr_i),
    .wdata_i   (dat_wdata_i),
    .rd_req_i  (dat_rd_req),
    .rd_index_i(dat_rd_index),
    .rd_data_o (dat_rd_data)
  );

  flow_fsm flow_fsm_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flow_en_i     (flow_en_i),
    .cmd_rvalid_i  (cmd_rvalid),
    .cmd_rready_o  (cmd_rready),
    .cmd_rdata_i   (cmd_rdata),
    .dat_rd_req_o  (dat_rd_req),
    .dat_rd_index_o(dat_rd_index),
    .dat_rd_data_i (dat_rd_data),
    .cmd_desc_o    (cmd_desc),
    .dat_entry_o   (dat_entry),
    .cnt_clr_o     (cnt_clr),
    .cnt_inc_o     (cnt_inc),
    .cnt_last_i    (cnt_last),
    .fmt_valid_o   (fmt_valid_o),
    .fmt_ready_i   (fmt_ready_i),
    .resp_wvalid_o (resp_wvalid),
    .resp_wready_i (resp_wready),
    .resp_wdata_o  (resp_wdata),
    .flow_idle_o   (flow_idle_o)
  );

  // Target is the payload length, position 0 being the address
  transfer_counter transfer_counter_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clr_i   (cnt_clr),
    .inc_i   (cnt_inc),
    .target_i(payload_len),
    .count_o (cnt_value),
    .last_o  (cnt_last)
  );

  imm_byte_sel imm_byte_sel_i (
    .cmd_desc_i   (cmd_desc),
    .dat_entry_i  (dat_entry),
    .count_i      (cnt_value),
    .last_i       (cnt_last),
    .payload_len_o(payload_len),
    .fmt_byte_o   (fmt_byte_o),
    .fmt_start_o  (fmt_start_o),
    .fmt_stop_o   (fmt_stop_o)
  );

  // Response queue
  hci_queue #(
    .Depth(RespDepth),
    .Width($bits(hci_flow_pkg::resp_desc_t))
  ) resp_queue_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(resp_wvalid),
    .wready_o(resp_wready),
    .wdata_i (resp_wdata),
    .rvalid_o(resp_rvalid_o),
    .rready_i(resp_rready_i),
    .rdata_o (resp_rdata_o)
  );

endmodule

/* testbench/tb_hci_flow_top.sv */
// Random immediate-write traffic against a queue-based model of the byte stream and responses
// DAT gets a random mix of I2C and I3C entries, the FSM is checked idle while flow_en_i is low
`timescale 1ns/1ps

module tb_hci_flow_top;

  localparam int unsigned HoldCmds = 4;
  localparam int unsigned RandCmds = 60;
  // About 20 cycles per command under back-pressure, plus DAT setup and the hold phase
  localparam int unsigned CycleLimit = (HoldCmds + RandCmds) * 20 + 300;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     cmd_wvalid_i;
  logic                     cmd_wready_o;
  hci_flow_pkg::cmd_desc_t  cmd_wdata_i;
  logic                     dat_wen_i;
  hci_flow_pkg::dat_index_t dat_waddr_i;
  hci_flow_pkg::dat_entry_t dat_wdata_i;
  logic                     flow_en_i;
  logic                     fmt_valid_o;
  logic                     fmt_ready_i;
  hci_flow_pkg::fmt_byte_t  fmt_byte_o;
  logic                     fmt_start_o;
  logic                     fmt_stop_o;
  logic                     resp_rvalid_o;
  logic                     resp_rready_i;
  hci_flow_pkg::resp_desc_t resp_rdata_o;
  logic                     flow_idle_o;

  // Model state: DAT copy, expected {start, stop, byte} and expected responses
  hci_flow_pkg::dat_entry_t dat_model [32];
  logic [9:0]               exp_bytes [$];
  logic [31:0]              exp_resps [$];
  logic [9:0]               exp_byte;
  logic [31:0]              exp_resp;
  int unsigned              errors;
  int unsigned              bytes_seen;
  int unsigned              resps_seen;
  int unsigned              cycles;
  logic                     rand_ready;
  // Byte offered but not taken on the previous edge
  logic                     fmt_stalled;
  logic [9:0]               fmt_held;

  hci_flow_top #(
    .CmdDepth (4),
    .RespDepth(4),
    .DatDepth (32)
  ) hci_flow_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_wvalid_i (cmd_wvalid_i),
    .cmd_wready_o (cmd_wready_o),
    .cmd_wdata_i  (cmd_wdata_i),
    .dat_wen_i    (dat_wen_i),
    .dat_waddr_i  (dat_waddr_i),
    .dat_wdata_i  (dat_wdata_i),
    .flow_en_i    (flow_en_i),
    .fmt_valid_o  (fmt_valid_o),
    .fmt_ready_i  (fmt_ready_i),
    .fmt_byte_o   (fmt_byte_o),
    .fmt_start_o  (fmt_start_o),
    .fmt_stop_o   (fmt_stop_o),
    .resp_rvalid_o(resp_rvalid_o),
    .resp_rready_i(resp_rready_i),
    .resp_rdata_o (resp_rdata_o),
    .flow_idle_o  (flow_idle_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Mostly supported immediates, some other attributes and reads
  function automatic hci_flow_pkg::cmd_desc_t random_cmd();
    hci_flow_pkg::cmd_desc_t desc;
    logic [2:0]              others [4];
    others = '{3'd0, 3'd2, 3'd3, 3'd7};
    desc = {$urandom, $urandom};
    desc[2:0]   = ($urandom % 8 < 5) ? 3'd1 : others[$urandom % 4];
    desc[29]    = (($urandom % 8) == 0);
    return desc;
  endfunction

  // Expected stream from the descriptor rules and the DAT copy
  task automatic predict(input hci_flow_pkg::cmd_desc_t desc);
    logic [2:0]  dtt;
    logic [4:0]  idx;
    int unsigned plen;
    int unsigned first;
    logic        toc;
    logic        ok;
    dtt  = desc[25:23];
    idx  = desc[20:16];
    toc  = desc[31];
    ok   = (desc[2:0] == 3'd1) && !desc[29] && dat_model[idx][31];
    plen = (dtt >= 5) ? dtt - 5 : dtt;
    first = (dtt >= 5) ? 2 : 1;
    if (ok) begin
      exp_bytes.push_back({1'b1, toc && (plen == 0), dat_model[idx][22:16], 1'b0});
      for (int k = 0; k < plen; k++) begin
        exp_bytes.push_back({1'b0, toc && (k == plen - 1), desc[32 + 8 * (first + k - 1) +: 8]});
      end
      exp_resps.push_back({4'h0, desc[6:3], 24'h0});
    end else begin
      exp_resps.push_back({hci_flow_pkg::RespNotSupported, desc[6:3], 24'h0});
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic push_cmd(input hci_flow_pkg::cmd_desc_t desc);
    predict(desc);
    cmd_wvalid_i = 1'b1;
    cmd_wdata_i  = desc;
    while (!cmd_wready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    cmd_wvalid_i = 1'b0;
  endtask

  // Random back-pressure on both output ports
  always @(negedge clk_i) begin
    if (rand_ready) begin
      fmt_ready_i   = ($urandom % 4) != 0;
      resp_rready_i = ($urandom % 3) != 0;
    end
  end

  // Byte and response monitors
  always @(posedge clk_i) begin
    // A stalled byte and its flags stay put until taken
    if (rst_ni && fmt_stalled) begin
      check_val("fmt_valid_o", fmt_valid_o, 1'b1);
      check_val("fmt_byte_o", fmt_byte_o, fmt_held[7:0]);
      check_val("fmt_start_o", fmt_start_o, fmt_held[9]);
      check_val("fmt_stop_o", fmt_stop_o, fmt_held[8]);
    end
    fmt_stalled = rst_ni && fmt_valid_o && !fmt_ready_i;
    fmt_held    = {fmt_start_o, fmt_stop_o, fmt_byte_o};
    if (rst_ni && fmt_valid_o && fmt_ready_i) begin
      bytes_seen++;
      if (exp_bytes.size() == 0) begin
        errors++;
        $display("Format byte 0x%0h was sent when no byte was expected", fmt_byte_o);
      end else begin
        exp_byte = exp_bytes.pop_front();
        check_val("fmt_byte_o", fmt_byte_o, exp_byte[7:0]);
        check_val("fmt_start_o", fmt_start_o, exp_byte[9]);
        check_val("fmt_stop_o", fmt_stop_o, exp_byte[8]);
      end
    end
    if (rst_ni && resp_rvalid_o && resp_rready_i) begin
      resps_seen++;
      if (exp_resps.size() == 0) begin
        errors++;
        $display("Response 0x%0h came out with no command pending", resp_rdata_o);
      end else begin
        exp_resp = exp_resps.pop_front();
        check_val("resp_rdata_o", resp_rdata_o, exp_resp);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Run did not finish within %0d cycles", CycleLimit);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(7));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    cmd_wvalid_i  = 1'b0;
    cmd_wdata_i   = '0;
    dat_wen_i     = 1'b0;
    dat_waddr_i   = '0;
    dat_wdata_i   = '0;
    flow_en_i     = 1'b0;
    fmt_ready_i   = 1'b0;
    resp_rready_i = 1'b0;
    rand_ready    = 1'b0;
    errors        = 0;
    bytes_seen    = 0;
    resps_seen    = 0;
    cycles        = 0;
    fmt_stalled   = 1'b0;
    fmt_held      = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_val("flow_idle_o", flow_idle_o, 1'b1);
    check_val("fmt_valid_o", fmt_valid_o, 1'b0);
    check_val("resp_rvalid_o", resp_rvalid_o, 1'b0);
    @(negedge clk_i);
    check_val("cmd_wready_o", cmd_wready_o, 1'b1);

    // About one entry in four is an I3C device
    for (int i = 0; i < 32; i++) begin
      dat_model[i]     = $urandom;
      dat_model[i][31] = ($urandom % 4) != 0;
      dat_wen_i   = 1'b1;
      dat_waddr_i = i[4:0];
      dat_wdata_i = dat_model[i];
      @(negedge clk_i);
    end
    dat_wen_i  = 1'b0;
    rand_ready = 1'b1;

    // Flow disabled, commands must stay queued
    for (int i = 0; i < HoldCmds; i++) begin
      push_cmd(random_cmd());
    end
    repeat (10) begin
      @(negedge clk_i);
      check_val("flow_idle_o", flow_idle_o, 1'b1);
      check_val("resp_rvalid_o", resp_rvalid_o, 1'b0);
      // Command queue still full
      check_val("cmd_wready_o", cmd_wready_o, 1'b0);
    end
    flow_en_i = 1'b1;

    for (int i = 0; i < RandCmds; i++) begin
      repeat ($urandom % 3) @(negedge clk_i);
      push_cmd(random_cmd());
    end

    // Drain, then stay quiet for a few cycles to catch stray outputs
    while (exp_bytes.size() != 0 || exp_resps.size() != 0 || !flow_idle_o) begin
      @(negedge clk_i);
    end
    repeat (8) @(negedge clk_i);
    check_val("resp_rvalid_o", resp_rvalid_o, 1'b0);

    $display("%0d errors, %0d bytes and %0d responses checked", errors, bytes_seen, resps_seen);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* hci_flow_top.f */
design/hci_flow_pkg.sv
design/hci_queue.sv
design/dat_table.sv
design/flow_fsm.sv
design/transfer_counter.sv
design/imm_byte_sel.sv
design/hci_flow_top.sv
testbench/tb_hci_flow_top.sv

/* Bender.yml */
package:
  name: hci_flow_top

sources:
  - design/hci_flow_pkg.sv
  - design/hci_queue.sv
  - design/dat_table.sv
  - design/flow_fsm.sv
  - design/transfer_counter.sv
  - design/imm_byte_sel.sv
  - design/hci_flow_top.sv
  - target: simulation
    files:
      - testbench/tb_hci_flow_top.sv
